// ==== list.f ====
pcxt_pkg.sv
pcxt_config.sv
pcxt_clock_sync.sv
pcxt_reset_seq.sv
pcxt_bios_loader.sv
pcxt_audio_out.sv
pcxt_core.sv
tb_pcxt_core.sv

// ==== pcxt_audio_out.sv ====
// sound mixer and sigma-delta output
`timescale 1ns/100ps
`default_nettype none

module pcxt_audio_out (
	input wire clk_chipset,
	input wire reset_wire,
	input pcxt_pkg::opl_sample_t opl_i,
	input pcxt_pkg::tandy_sample_t tandy_i,
	input wire speaker_i,
	output pcxt_pkg::mix_t mix_o,
	output logic audio_o
);

	pcxt_pkg::mix_t mix_next;
	logic [14:0] dac_in;
	logic [14:0] acc;
	logic [15:0] acc_sum;

	////////////////////////////////////////////////////////////
	// mixer
	////////////////////////////////////////////////////////////

	// opl sign extended, speaker is active low, tandy x4
	assign mix_next = {opl_i[15], opl_i} +
		(speaker_i ? 17'd0 : 17'd16384) +
		{1'b0, tandy_i, 2'b00};

	// top 15 bits feed the modulator as unsigned
	assign dac_in = mix_o[16:2];
	assign acc_sum = {1'b0, acc} + {1'b0, dac_in};

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			mix_o <= '0;
			acc <= '0;
			audio_o <= 1'b0;
		end else begin
			mix_o <= mix_next;
			// first order loop, carry is the bitstream
			acc <= acc_sum[14:0];
			audio_o <= acc_sum[15];
		end
	end

endmodule

`default_nettype wire

// ==== pcxt_bios_loader.sv ====
// bios and xtide rom loader
`timescale 1ns/100ps
`default_nettype none

module pcxt_bios_loader (
	input wire clk_chipset,
	input wire reset_wire,
	input wire download_i,
	input pcxt_pkg::dl_index_t index_i,
	input wire wr_i,
	input pcxt_pkg::dl_addr_t addr_i,
	input pcxt_pkg::byte_t data_i,
	input wire cpu_fall_i,
	output logic boot_load_o,
	output logic mem_req_o,
	output logic mem_wr_n_o,
	output pcxt_pkg::mem_addr_t mem_addr_o,
	output pcxt_pkg::byte_t mem_data_o
);

	localparam int CNT_W = $clog2(pcxt_pkg::WRITE_FALLS + 1);

	pcxt_pkg::loader_state_t state;
	logic [CNT_W-1:0] fall_cnt;
	logic bios_win;
	logic xtide_win;
	pcxt_pkg::mem_addr_t map_addr;
	logic accept;

	// index 0 download is the main bios, keeps the machine in reset
	assign boot_load_o = download_i && (index_i == 8'd0);

	////////////////////////////////////////////////////////////
	// download address to rom window
	////////////////////////////////////////////////////////////

	// 64k bios image, second 64k of file 0 is xtide
	assign bios_win = (index_i < 8'd2) && (addr_i[24:16] == 9'd0);
	assign xtide_win = (index_i == 8'd2) ||
		((index_i == 8'd0) && (addr_i[24:16] == 9'd1));

	always_comb begin
		if (bios_win) begin
			map_addr = pcxt_pkg::BIOS_BASE + pcxt_pkg::mem_addr_t'(addr_i[15:0]);
		end else if (xtide_win) begin
			map_addr = pcxt_pkg::XTIDE_BASE + pcxt_pkg::mem_addr_t'(addr_i[13:0]);
		end else begin
			map_addr = pcxt_pkg::NO_ADDR;
		end
	end

	// strobe only taken while waiting for one
	assign accept = (state == pcxt_pkg::LD_WAIT_STROBE) && download_i && wr_i;

	////////////////////////////////////////////////////////////
	// write cycle fsm
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			state <= pcxt_pkg::LD_IDLE;
			fall_cnt <= '0;
			mem_req_o <= 1'b0;
			mem_wr_n_o <= 1'b1;
			mem_addr_o <= pcxt_pkg::NO_ADDR;
		end else begin
			mem_req_o <= download_i;
			if (!download_i) begin
				// download gone, abort any write in flight
				state <= pcxt_pkg::LD_IDLE;
				fall_cnt <= '0;
				mem_wr_n_o <= 1'b1;
				mem_addr_o <= pcxt_pkg::NO_ADDR;
			end else begin
				case (state)
					pcxt_pkg::LD_IDLE: begin
						// one idle cycle before strobes count
						state <= pcxt_pkg::LD_WAIT_STROBE;
					end
					pcxt_pkg::LD_WAIT_STROBE: begin
						fall_cnt <= '0;
						if (accept) begin
							mem_wr_n_o <= 1'b0;
							mem_addr_o <= map_addr;
							state <= pcxt_pkg::LD_WRITE;
						end else begin
							mem_addr_o <= pcxt_pkg::NO_ADDR;
						end
					end
					pcxt_pkg::LD_WRITE: begin
						// hold for a few bus clocks, extra strobes dropped
						if (fall_cnt == CNT_W'(pcxt_pkg::WRITE_FALLS)) begin
							mem_wr_n_o <= 1'b1;
							state <= pcxt_pkg::LD_WAIT_STROBE;
						end else if (cpu_fall_i) begin
							fall_cnt <= fall_cnt + 1'b1;
						end
					end
					default: begin
						state <= pcxt_pkg::LD_IDLE;
						mem_wr_n_o <= 1'b1;
					end
				endcase
			end
		end
	end

	// write data, only looked at while the strobe is low
	always_ff @(posedge clk_chipset) begin
		if (accept) begin
			mem_data_o <= data_i;
		end
	end

endmodule

`default_nettype wire

// ==== pcxt_clock_sync.sv ====
// slow clock synchronizers and enables
`timescale 1ns/100ps
`default_nettype none

module pcxt_clock_sync (
	input wire clk_chipset,
	input wire reset_wire,
	input pcxt_pkg::cpu_speed_t cpu_speed_i,
	input wire uart_fast_i,
	input wire clk_14_i,
	input wire clk_7_i,
	input wire clk_4_i,
	input wire opl2_clk_i,
	input wire uart_clk_i,
	input wire uart2_clk_i,
	output logic cpu_clk_o,
	output logic cpu_fall_o,
	output logic opl2_ce_o,
	output logic uart_ce_o
);

	// lanes of the synchronizer vectors
	localparam int CH_CPU = 0;
	localparam int CH_OPL2 = 1;
	localparam int CH_UART = 2;
	localparam int CH_UART2 = 3;

	logic sel_clk;
	logic [3:0] raw_clks;
	logic [3:0] sync_1;
	logic [3:0] sync_2;
	logic [3:0] sync_3;
	logic uart_rise;

	// cpu clock picked before the synchronizer
	always_comb begin
		case (cpu_speed_i)
			pcxt_pkg::SPEED_14_318: sel_clk = clk_14_i;
			pcxt_pkg::SPEED_7_16: sel_clk = clk_7_i;
			default: sel_clk = clk_4_i;
		endcase
	end

	assign raw_clks = {uart2_clk_i, uart_clk_i, opl2_clk_i, sel_clk};

	////////////////////////////////////////////////////////////
	// three stage synchronizers and edge pulses
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			sync_1 <= '0;
			sync_2 <= '0;
			sync_3 <= '0;
			cpu_fall_o <= 1'b0;
			opl2_ce_o <= 1'b0;
			uart_rise <= 1'b0;
		end else begin
			sync_1 <= raw_clks;
			sync_2 <= sync_1;
			sync_3 <= sync_2;
			// stage 3 still high, stage 2 already low
			cpu_fall_o <= sync_3[CH_CPU] & ~sync_2[CH_CPU];
			opl2_ce_o <= sync_2[CH_OPL2] & ~sync_3[CH_OPL2];
			uart_rise <= sync_2[CH_UART] & ~sync_3[CH_UART];
		end
	end

	assign cpu_clk_o = sync_3[CH_CPU];

	// slow range runs the uart straight off the 1.8432 level
	assign uart_ce_o = uart_fast_i ? uart_rise : sync_3[CH_UART2];

endmodule

`default_nettype wire

// ==== pcxt_config.sv ====
// configuration register block
`timescale 1ns/100ps
`default_nettype none

module pcxt_config (
	input wire clk_chipset,
	input wire reset_wire,
	input pcxt_pkg::status_t status_i,
	input wire sys_reset_i,
	output pcxt_pkg::cpu_speed_t cpu_speed_o,
	output logic uart_fast_o,
	output logic tandy_mode_o,
	output logic soft_reset_o
);

	// raw two bit fields out of the status word
	logic [1:0] speed_code;
	logic [1:0] uart_code;

	assign speed_code = status_i[pcxt_pkg::ST_SPEED_LO +: 2];
	assign uart_code = status_i[pcxt_pkg::ST_UART_LO +: 2];

	////////////////////////////////////////////////////////////
	// field registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			cpu_speed_o <= pcxt_pkg::SPEED_4_77;
			uart_fast_o <= 1'b0;
			tandy_mode_o <= 1'b0;
			soft_reset_o <= 1'b0;
		end else begin
			// reserved code falls back to the slow clock
			case (speed_code)
				2'b01: cpu_speed_o <= pcxt_pkg::SPEED_7_16;
				2'b10: cpu_speed_o <= pcxt_pkg::SPEED_14_318;
				default: cpu_speed_o <= pcxt_pkg::SPEED_4_77;
			endcase
			// 00 is the 1200..115200 range, anything else fast
			uart_fast_o <= (uart_code != 2'b00);
			// menu reset toggle
			soft_reset_o <= status_i[pcxt_pkg::ST_RESET];
			// model only latched while the system sits in reset
			if (sys_reset_i) begin
				tandy_mode_o <= status_i[pcxt_pkg::ST_MODEL];
			end
		end
	end

endmodule

`default_nettype wire

// ==== pcxt_core.sv ====
// pc/xt chipset glue top
`timescale 1ns/100ps
`default_nettype none

module pcxt_core #(
	parameter int POWER_ON_CYCLES = 65535,
	parameter int CPU_RESET_CYCLES = 42
) (
	input wire clk_chipset,
	input wire reset_wire,
	input pcxt_pkg::status_t status_i,
	input wire clk_14_i,
	input wire clk_7_i,
	input wire clk_4_i,
	input wire opl2_clk_i,
	input wire uart_clk_i,
	input wire uart2_clk_i,
	input wire download_i,
	input pcxt_pkg::dl_index_t index_i,
	input wire wr_i,
	input pcxt_pkg::dl_addr_t addr_i,
	input pcxt_pkg::byte_t data_i,
	input pcxt_pkg::opl_sample_t opl_i,
	input pcxt_pkg::tandy_sample_t tandy_i,
	input wire speaker_i,
	output logic sys_reset_o,
	output logic cpu_reset_o,
	output logic cpu_clk_o,
	output logic opl2_ce_o,
	output logic uart_ce_o,
	output logic tandy_mode_o,
	output logic mem_req_o,
	output logic mem_wr_n_o,
	output pcxt_pkg::mem_addr_t mem_addr_o,
	output pcxt_pkg::byte_t mem_data_o,
	output pcxt_pkg::mix_t mix_o,
	output logic audio_o
);

	pcxt_pkg::cpu_speed_t cpu_speed;
	logic uart_fast;
	logic soft_reset;
	logic cpu_fall;
	logic boot_load;

	////////////////////////////////////////////////////////////
	// config, clocks, reset
	////////////////////////////////////////////////////////////

	pcxt_config config_inst (
		.clk_chipset (clk_chipset),
		.reset_wire (reset_wire),
		.status_i (status_i),
		.sys_reset_i (sys_reset_o),
		.cpu_speed_o (cpu_speed),
		.uart_fast_o (uart_fast),
		.tandy_mode_o (tandy_mode_o),
		.soft_reset_o (soft_reset)
	);

	pcxt_clock_sync clock_sync_inst (
		.clk_chipset (clk_chipset),
		.reset_wire (reset_wire),
		.cpu_speed_i (cpu_speed),
		.uart_fast_i (uart_fast),
		.clk_14_i (clk_14_i),
		.clk_7_i (clk_7_i),
		.clk_4_i (clk_4_i),
		.opl2_clk_i (opl2_clk_i),
		.uart_clk_i (uart_clk_i),
		.uart2_clk_i (uart2_clk_i),
		.cpu_clk_o (cpu_clk_o),
		.cpu_fall_o (cpu_fall),
		.opl2_ce_o (opl2_ce_o),
		.uart_ce_o (uart_ce_o)
	);

	pcxt_reset_seq #(
		.POWER_ON_CYCLES (POWER_ON_CYCLES),
		.CPU_RESET_CYCLES (CPU_RESET_CYCLES)
	) reset_seq_inst (
		.clk_chipset (clk_chipset),
		.reset_wire (reset_wire),
		.soft_reset_i (soft_reset),
		.boot_load_i (boot_load),
		.sys_reset_o (sys_reset_o),
		.cpu_reset_o (cpu_reset_o)
	);

	////////////////////////////////////////////////////////////
	// rom loader and audio
	////////////////////////////////////////////////////////////

	pcxt_bios_loader bios_loader_inst (
		.clk_chipset (clk_chipset),
		.reset_wire (reset_wire),
		.download_i (download_i),
		.index_i (index_i),
		.wr_i (wr_i),
		.addr_i (addr_i),
		.data_i (data_i),
		.cpu_fall_i (cpu_fall),
		.boot_load_o (boot_load),
		.mem_req_o (mem_req_o),
		.mem_wr_n_o (mem_wr_n_o),
		.mem_addr_o (mem_addr_o),
		.mem_data_o (mem_data_o)
	);

	pcxt_audio_out audio_out_inst (
		.clk_chipset (clk_chipset),
		.reset_wire (reset_wire),
		.opl_i (opl_i),
		.tandy_i (tandy_i),
		.speaker_i (speaker_i),
		.mix_o (mix_o),
		.audio_o (audio_o)
	);

endmodule

`default_nettype wire

// ==== pcxt_pkg.sv ====
// pcxt chipset glue definitions
`default_nettype none

package pcxt_pkg;

	////////////////////////////////////////////////////////////
	// widths with a meaning
	////////////////////////////////////////////////////////////

	// host status word from the menu system
	typedef logic [31:0] status_t;
	// 8088 physical address
	typedef logic [19:0] mem_addr_t;
	typedef logic [7:0] byte_t;
	// host download bus
	typedef logic [24:0] dl_addr_t;
	typedef logic [7:0] dl_index_t;
	// sound sources
	typedef logic signed [15:0] opl_sample_t;
	typedef logic [13:0] tandy_sample_t;
	typedef logic [16:0] mix_t;

	// cpu clock choice, code 11 is reserved and maps to 4.77
	typedef enum logic [1:0] {
		SPEED_4_77 = 2'b00,
		SPEED_7_16 = 2'b01,
		SPEED_14_318 = 2'b10
	} cpu_speed_t;

	// rom loader states
	typedef enum logic [1:0] {
		LD_IDLE,
		LD_WAIT_STROBE,
		LD_WRITE
	} loader_state_t;

	////////////////////////////////////////////////////////////
	// rom windows and status bit map
	////////////////////////////////////////////////////////////

	parameter mem_addr_t BIOS_BASE = 20'hF0000;
	parameter mem_addr_t XTIDE_BASE = 20'hEC000;
	parameter mem_addr_t NO_ADDR = 20'hFFFFF;
	// cpu clock falls per write cycle
	parameter int WRITE_FALLS = 4;

	parameter int ST_RESET = 0;
	parameter int ST_MODEL = 3;
	parameter int ST_SPEED_LO = 17;
	parameter int ST_UART_LO = 21;

endpackage

`default_nettype wire

// ==== pcxt_reset_seq.sv ====
// system and cpu reset sequencer
`timescale 1ns/100ps
`default_nettype none

module pcxt_reset_seq #(
	parameter int POWER_ON_CYCLES = 65535,
	parameter int CPU_RESET_CYCLES = 42
) (
	input wire clk_chipset,
	input wire reset_wire,
	input wire soft_reset_i,
	input wire boot_load_i,
	output logic sys_reset_o,
	output logic cpu_reset_o
);

	localparam int PO_W = $clog2(POWER_ON_CYCLES + 1);
	localparam int CR_W = $clog2(CPU_RESET_CYCLES + 1);

	logic request;
	logic [PO_W-1:0] po_cnt;
	logic [CR_W-1:0] cr_cnt;

	// menu reset or bios download both restart everything
	assign request = soft_reset_i | boot_load_i;

	////////////////////////////////////////////////////////////
	// power-on stretch
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			sys_reset_o <= 1'b1;
			po_cnt <= '0;
		end else if (request) begin
			sys_reset_o <= 1'b1;
			po_cnt <= '0;
		end else if (sys_reset_o) begin
			// drop on the last counted edge
			if (po_cnt == PO_W'(POWER_ON_CYCLES - 1)) begin
				sys_reset_o <= 1'b0;
			end else begin
				po_cnt <= po_cnt + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// cpu reset tail
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			cpu_reset_o <= 1'b1;
			cr_cnt <= '0;
		end else if (request || sys_reset_o) begin
			cpu_reset_o <= 1'b1;
			cr_cnt <= '0;
		end else if (cpu_reset_o) begin
			if (cr_cnt == CR_W'(CPU_RESET_CYCLES - 1)) begin
				cpu_reset_o <= 1'b0;
			end else begin
				cr_cnt <= cr_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb_pcxt_core.sv ====
// pcxt chipset glue testbench
`timescale 1ns/100ps
`default_nettype none

module tb_pcxt_core;

	localparam int PO_CYCLES = 20;
	localparam int CR_CYCLES = 6;
	localparam int N_LOAD = 8;
	localparam int N_MIX = 9;
	localparam int DAC_CYCLES = 1024;
	localparam int WAIT_LIMIT = 400;
	// speed code 01 in bits 18..17 and nothing else set
	localparam logic [31:0] STATUS_7MHZ = 32'h0002_0000;
	// model bit 3 selects tandy
	localparam logic [31:0] STATUS_MODEL = 32'h0000_0008;
	// watched signal selectors
	localparam int W_SYS = 0;
	localparam int W_CPU = 1;
	localparam int W_REQ = 2;
	localparam int W_WRN = 3;

	typedef struct packed {
		pcxt_pkg::dl_index_t idx;
		pcxt_pkg::dl_addr_t addr;
		pcxt_pkg::byte_t data;
		pcxt_pkg::mem_addr_t exp_addr;
	} load_row_t;

	typedef struct packed {
		pcxt_pkg::opl_sample_t opl;
		pcxt_pkg::tandy_sample_t tandy;
		logic speaker;
		pcxt_pkg::mix_t exp_mix;
	} mix_row_t;

	logic clk_chipset;
	logic reset_wire;
	pcxt_pkg::status_t status_i;
	// 14.318, 7.16, 4.77, opl2, uart, uart2
	logic [5:0] slow_clk;
	logic [3:0] tog_cnt [6];
	logic download_i;
	pcxt_pkg::dl_index_t index_i;
	logic wr_i;
	pcxt_pkg::dl_addr_t addr_i;
	pcxt_pkg::byte_t data_i;
	pcxt_pkg::opl_sample_t opl_i;
	pcxt_pkg::tandy_sample_t tandy_i;
	logic speaker_i;
	logic sys_reset_o;
	logic cpu_reset_o;
	logic cpu_clk_o;
	logic opl2_ce_o;
	logic uart_ce_o;
	logic tandy_mode_o;
	logic mem_req_o;
	logic mem_wr_n_o;
	pcxt_pkg::mem_addr_t mem_addr_o;
	pcxt_pkg::byte_t mem_data_o;
	pcxt_pkg::mix_t mix_o;
	logic audio_o;

	load_row_t load_tab [N_LOAD];
	mix_row_t mix_tab [N_MIX];
	integer seed;
	int errors;
	int tests;
	int failed_tests;
	int err_mark;
	int edges;

	pcxt_core #(
		.POWER_ON_CYCLES (PO_CYCLES),
		.CPU_RESET_CYCLES (CR_CYCLES)
	) pcxt_core_inst (
		.clk_chipset (clk_chipset),
		.reset_wire (reset_wire),
		.status_i (status_i),
		.clk_14_i (slow_clk[0]),
		.clk_7_i (slow_clk[1]),
		.clk_4_i (slow_clk[2]),
		.opl2_clk_i (slow_clk[3]),
		.uart_clk_i (slow_clk[4]),
		.uart2_clk_i (slow_clk[5]),
		.download_i (download_i),
		.index_i (index_i),
		.wr_i (wr_i),
		.addr_i (addr_i),
		.data_i (data_i),
		.opl_i (opl_i),
		.tandy_i (tandy_i),
		.speaker_i (speaker_i),
		.sys_reset_o (sys_reset_o),
		.cpu_reset_o (cpu_reset_o),
		.cpu_clk_o (cpu_clk_o),
		.opl2_ce_o (opl2_ce_o),
		.uart_ce_o (uart_ce_o),
		.tandy_mode_o (tandy_mode_o),
		.mem_req_o (mem_req_o),
		.mem_wr_n_o (mem_wr_n_o),
		.mem_addr_o (mem_addr_o),
		.mem_data_o (mem_data_o),
		.mix_o (mix_o),
		.audio_o (audio_o)
	);

	always #20 clk_chipset = ~clk_chipset;

	////////////////////////////////////////////////////////////
	// slow clock models
	////////////////////////////////////////////////////////////

	// distinct half periods in chipset cycles
	function automatic int half_period(input int ch);
		case (ch)
			0: return 2;
			1: return 3;
			2: return 5;
			3: return 4;
			4: return 6;
			default: return 7;
		endcase
	endfunction

	always @(posedge clk_chipset) begin
		for (int i = 0; i < 6; i++) begin
			if (tog_cnt[i] == 4'(half_period(i) - 1)) begin
				tog_cnt[i] <= '0;
				slow_clk[i] <= ~slow_clk[i];
			end else begin
				tog_cnt[i] <= tog_cnt[i] + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	function automatic logic watched(input int sel);
		case (sel)
			W_SYS: return sys_reset_o;
			W_CPU: return cpu_reset_o;
			W_REQ: return mem_req_o;
			default: return mem_wr_n_o;
		endcase
	endfunction

	function automatic string watched_name(input int sel);
		case (sel)
			W_SYS: return "sys_reset_o";
			W_CPU: return "cpu_reset_o";
			W_REQ: return "mem_req_o";
			default: return "mem_wr_n_o";
		endcase
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("[FAIL] %s got %h expected %h", name, got, exp);
		errors++;
	endtask

	task automatic begin_test;
		err_mark = errors;
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == err_mark) begin
			$display("test %s: ok", name);
		end else begin
			failed_tests++;
			$display("test %s: %0d error(s)", name, errors - err_mark);
		end
	endtask

	// counts rising edges until the signal reads level at the falling edge
	task automatic wait_level(input int sel, input logic level, output int n);
		logic cur;
		n = 0;
		cur = ~level;
		while (cur !== level && n < WAIT_LIMIT) begin
			@(posedge clk_chipset);
			n++;
			@(negedge clk_chipset);
			cur = watched(sel);
		end
		if (cur !== level) begin
			$display("timeout waiting for %s to reach %0b", watched_name(sel), level);
			errors++;
		end
	endtask

	task automatic fill_tables;
		logic [31:0] rnd;
		load_tab[0] = {8'd0, 25'h0001234, 8'h00, 20'hF1234};
		load_tab[1] = {8'd1, 25'h000ABCD, 8'h00, 20'hFABCD};
		load_tab[2] = {8'd0, 25'h0010123, 8'h00, 20'hEC123};
		load_tab[3] = {8'd2, 25'h0003FFF, 8'h00, 20'hEFFFF};
		load_tab[4] = {8'd2, 25'h0125678, 8'h00, 20'hED678};
		load_tab[5] = {8'd1, 25'h0020000, 8'h00, 20'hFFFFF};
		load_tab[6] = {8'd5, 25'h0000010, 8'h00, 20'hFFFFF};
		load_tab[7] = {8'd0, 25'h0030000, 8'h00, 20'hFFFFF};
		for (int i = 0; i < N_LOAD; i++) begin
			rnd = $random(seed);
			load_tab[i].data = rnd[7:0];
		end
		// opl, tandy, speaker, expected mix
		mix_tab[0] = {16'h0000, 14'h0000, 1'b1, 17'h00000};
		mix_tab[1] = {16'h0000, 14'h0000, 1'b0, 17'h04000};
		mix_tab[2] = {16'h7FFF, 14'h0000, 1'b1, 17'h07FFF};
		mix_tab[3] = {16'h8000, 14'h0000, 1'b1, 17'h18000};
		mix_tab[4] = {16'h1000, 14'h0100, 1'b0, 17'h05400};
		mix_tab[5] = {16'hFFFF, 14'h3FFF, 1'b0, 17'h13FFB};
		mix_tab[6] = {16'h7FFF, 14'h3FFF, 1'b0, 17'h1BFFB};
		mix_tab[7] = {16'h8000, 14'h2000, 1'b1, 17'h00000};
		// wraps past 17 bits
		mix_tab[8] = {16'hFFFF, 14'h0001, 1'b1, 17'h00003};
	endtask

	// cpu_clk_o is the selected raw level three samples back
	task automatic check_cpu_clock;
		logic [2:0] h14;
		logic [2:0] h7;
		logic [2:0] h4;
		int miss14;
		int miss4;
		h14 = '0;
		h7 = '0;
		h4 = '0;
		miss14 = 0;
		miss4 = 0;
		repeat (3) begin
			@(negedge clk_chipset);
			h14 = {h14[1:0], slow_clk[0]};
			h7 = {h7[1:0], slow_clk[1]};
			h4 = {h4[1:0], slow_clk[2]};
		end
		repeat (64) begin
			@(negedge clk_chipset);
			if (cpu_clk_o !== h7[2]) begin
				report_mismatch("cpu_clk_o", cpu_clk_o, h7[2]);
			end
			if (cpu_clk_o !== h14[2]) miss14++;
			if (cpu_clk_o !== h4[2]) miss4++;
			h14 = {h14[1:0], slow_clk[0]};
			h7 = {h7[1:0], slow_clk[1]};
			h4 = {h4[1:0], slow_clk[2]};
		end
		if (miss14 == 0 || miss4 == 0) begin
			$display("cpu_clk_o also tracks a clock that is not selected");
			errors++;
		end
	endtask

	task automatic run_loader_row(input load_row_t row);
		int n;
		int falls;
		logic prev7;
		@(posedge clk_chipset);
		download_i <= 1'b1;
		index_i <= row.idx;
		addr_i <= row.addr;
		data_i <= row.data;
		wait_level(W_REQ, 1'b1, n);
		if (n != 1) report_mismatch("mem_req_o rise edges", n, 1);
		// loader spends one cycle idle before a strobe counts
		@(posedge clk_chipset);
		wr_i <= 1'b1;
		@(posedge clk_chipset);
		wr_i <= 1'b0;
		wait_level(W_WRN, 1'b0, n);
		if (mem_addr_o !== row.exp_addr) begin
			report_mismatch("mem_addr_o", mem_addr_o, row.exp_addr);
		end
		if (mem_data_o !== row.data) report_mismatch("mem_data_o", mem_data_o, row.data);
		if (row.idx == 8'd0 && cpu_reset_o !== 1'b1) begin
			report_mismatch("cpu_reset_o", cpu_reset_o, 1'b1);
		end
		// raw 7.16 falls seen while the strobe is low
		falls = 0;
		n = 0;
		prev7 = slow_clk[1];
		while (mem_wr_n_o === 1'b0 && n < WAIT_LIMIT) begin
			@(negedge clk_chipset);
			n++;
			if (prev7 && !slow_clk[1]) falls++;
			prev7 = slow_clk[1];
		end
		if (mem_wr_n_o !== 1'b1) begin
			$display("timeout waiting for mem_wr_n_o to end the write");
			errors++;
		end
		if (falls < pcxt_pkg::WRITE_FALLS - 1 || falls > pcxt_pkg::WRITE_FALLS + 1) begin
			report_mismatch("clk_7_i falls in write", falls, pcxt_pkg::WRITE_FALLS);
		end
		@(posedge clk_chipset);
		download_i <= 1'b0;
		wait_level(W_REQ, 1'b0, n);
	endtask

	task automatic run_mixer_row(input mix_row_t row);
		int shifted;
		int ones;
		int exp_ones;
		@(posedge clk_chipset);
		opl_i <= row.opl;
		tandy_i <= row.tandy;
		speaker_i <= row.speaker;
		@(posedge clk_chipset);
		@(negedge clk_chipset);
		if (mix_o !== row.exp_mix) report_mismatch("mix_o", mix_o, row.exp_mix);
		// modulator and bit output each lag the new mix by a cycle
		repeat (2) @(negedge clk_chipset);
		shifted = int'(row.exp_mix[16:2]);
		exp_ones = (shifted * DAC_CYCLES) / 32768;
		ones = 0;
		repeat (DAC_CYCLES) begin
			@(negedge clk_chipset);
			if (audio_o === 1'b1) ones++;
		end
		if (ones > exp_ones + 2 || ones + 2 < exp_ones) begin
			report_mismatch("audio_o ones", ones, exp_ones);
		end
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		clk_chipset = 1'b0;
		reset_wire = 1'b1;
		status_i = '0;
		slow_clk = '0;
		for (int i = 0; i < 6; i++) begin
			tog_cnt[i] = '0;
		end
		download_i = 1'b0;
		index_i = '0;
		wr_i = 1'b0;
		addr_i = '0;
		data_i = '0;
		opl_i = '0;
		tandy_i = '0;
		speaker_i = 1'b1;
		seed = 32'h5193;
		errors = 0;
		tests = 0;
		failed_tests = 0;
		fill_tables();

		// values while reset_wire is held
		begin_test();
		@(negedge clk_chipset);
		if (sys_reset_o !== 1'b1) report_mismatch("sys_reset_o", sys_reset_o, 1'b1);
		if (cpu_reset_o !== 1'b1) report_mismatch("cpu_reset_o", cpu_reset_o, 1'b1);
		if (mem_wr_n_o !== 1'b1) report_mismatch("mem_wr_n_o", mem_wr_n_o, 1'b1);
		if (mem_req_o !== 1'b0) report_mismatch("mem_req_o", mem_req_o, 1'b0);
		if (mem_addr_o !== 20'hFFFFF) report_mismatch("mem_addr_o", mem_addr_o, 20'hFFFFF);
		if (opl2_ce_o !== 1'b0) report_mismatch("opl2_ce_o", opl2_ce_o, 1'b0);
		if (uart_ce_o !== 1'b0) report_mismatch("uart_ce_o", uart_ce_o, 1'b0);
		end_test("reset_values");

		// power-on release
		begin_test();
		repeat (10) @(posedge clk_chipset);
		reset_wire <= 1'b0;
		wait_level(W_SYS, 1'b0, edges);
		if (edges != PO_CYCLES) report_mismatch("sys_reset_o fall edges", edges, PO_CYCLES);
		wait_level(W_CPU, 1'b0, edges);
		if (edges != CR_CYCLES) report_mismatch("cpu_reset_o fall edges", edges, CR_CYCLES);
		end_test("power_on_sequence");

		// soft reset through status bit 0 with the model bit set
		begin_test();
		@(posedge clk_chipset);
		status_i <= 32'h0000_0001 | STATUS_MODEL;
		// the config register adds one edge
		wait_level(W_SYS, 1'b1, edges);
		if (edges != 2) report_mismatch("sys_reset_o rise edges", edges, 2);
		repeat (3) @(posedge clk_chipset);
		status_i <= STATUS_7MHZ | STATUS_MODEL;
		wait_level(W_SYS, 1'b0, edges);
		if (edges != PO_CYCLES + 1) begin
			report_mismatch("sys_reset_o fall edges", edges, PO_CYCLES + 1);
		end
		wait_level(W_CPU, 1'b0, edges);
		if (edges != CR_CYCLES) report_mismatch("cpu_reset_o fall edges", edges, CR_CYCLES);
		if (tandy_mode_o !== 1'b1) report_mismatch("tandy_mode_o", tandy_mode_o, 1'b1);
		// latched model holds once the cpu runs
		@(posedge clk_chipset);
		status_i <= STATUS_7MHZ;
		repeat (3) @(negedge clk_chipset);
		if (tandy_mode_o !== 1'b1) report_mismatch("tandy_mode_o", tandy_mode_o, 1'b1);
		end_test("soft_reset_sequence");

		begin_test();
		check_cpu_clock();
		end_test("cpu_clock_select");

		for (int i = 0; i < N_LOAD; i++) begin
			begin_test();
			run_loader_row(load_tab[i]);
			end_test($sformatf("loader_row_%0d", i));
		end

		for (int i = 0; i < N_MIX; i++) begin
			begin_test();
			run_mixer_row(mix_tab[i]);
			end_test($sformatf("mixer_row_%0d", i));
		end

		$display("tests run %0d, tests failed %0d, errors %0d", tests, failed_tests, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
